// File: rtl/rv_pipe_pkg.sv
/*
 * RV pipeline package
 * Widths, major opcodes, micro-ops and bus owner codes shared by the core
 */
package rv_pipe_pkg;

    // ------------------------------------------------------------
    // Widths and vector types
    // ------------------------------------------------------------
    localparam int XLEN       = 32;                 // Data and address width
    localparam int REG_ADDR_W = 5;                  // GPR index width

    typedef logic [XLEN-1:0]       word_t;          // Data word
    typedef logic [XLEN-1:0]       addr_t;          // Byte address
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;      // GPR index

    localparam addr_t PC_RESET = 32'h0000_0000;     // First fetch address

    // ------------------------------------------------------------
    // Major opcodes of the supported subset
    // ------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011; // ADD SUB AND OR XOR
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // ADDI
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LW
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // SW

    typedef enum logic [3:0] {
        NOP,                                        // Retires, no write
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B,                                     // LUI result
        LOAD,
        STORE
    } uop_t;

    // Owner of the bus transaction
    typedef enum logic {
        FETCH,
        MEMORY
    } arb_owner_t;

endpackage

// File: rtl/rv_pipe_if.sv
/*
 * Pipeline interfaces
 * Stage handoff, memory requester port and forwarding report
 */
`timescale 1ns/100ps

// Valid/ready handoff between stages
interface stage_if import rv_pipe_pkg::*; ();
    logic      valid;
    logic      ready;
    addr_t     pc;
    word_t     instr;                               // Carried for trace
    reg_addr_t rd;                                  // Zero when nothing written
    uop_t      uop;
    word_t     opr_a;
    word_t     opr_b;
    word_t     store_data;

    modport src (output valid, pc, instr, rd, uop, opr_a, opr_b, store_data, input ready);
    modport dst (input valid, pc, instr, rd, uop, opr_a, opr_b, store_data, output ready);
endinterface

// Requester side of the shared memory bus
interface mem_port_if import rv_pipe_pkg::*; ();
    logic  req;                                     // Held until gnt
    logic  wen;
    addr_t addr;
    word_t wdata;
    logic  gnt;
    logic  recv;                                    // One pulse per grant
    word_t rdata;

    modport requester (output req, wen, addr, wdata, input gnt, recv, rdata);
    modport arbiter   (input req, wen, addr, wdata, output gnt, recv, rdata);
endinterface

// Producer report for operand forwarding
interface fwd_if import rv_pipe_pkg::*; ();
    logic      valid;
    reg_addr_t rd;
    word_t     data;
    logic      is_load;                             // Data not ready yet

    modport src (output valid, rd, data, is_load);
    modport dst (input valid, rd, data, is_load);
endinterface

// File: rtl/rv_pipe_fetch.sv
/*
 * Fetch stage
 * Sequences word reads from the PC and holds each word until decode takes it
 */
`timescale 1ns/100ps

module rv_pipe_fetch import rv_pipe_pkg::*; (
    input  logic          g_clk,
    input  logic          rst,
    mem_port_if.requester mem,
    output logic          instr_valid,
    input  logic          instr_ready,
    output addr_t         instr_pc,
    output word_t         instr_word
);

    addr_t pc;                                      // Next fetch address
    logic  req_q;                                   // Request on the bus
    logic  pending;                                 // Granted, awaiting recv
    logic  hold_free;                               // Holding reg empty or draining

    assign hold_free = !instr_valid || instr_ready;

    assign mem.req   = req_q;
    assign mem.wen   = 1'b0;                        // Reads only
    assign mem.addr  = pc;
    assign mem.wdata = '0;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            pc          <= PC_RESET;
            req_q       <= 1'b0;
            pending     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (req_q && mem.gnt) begin
                req_q   <= 1'b0;
                pending <= 1'b1;
                pc      <= pc + 32'd4;              // Advance on grant
            end else if (!req_q && !pending && hold_free) begin
                req_q   <= 1'b1;
            end
            if (mem.recv) begin
                pending     <= 1'b0;
                instr_valid <= 1'b1;
            end else if (instr_ready) begin
                instr_valid <= 1'b0;                // Taken by decode
            end
        end
    end

    // Holding register payload
    always_ff @(posedge g_clk) begin
        if (mem.recv) begin
            instr_word <= mem.rdata;
            instr_pc   <= pc - 32'd4;               // PC already stepped at grant
        end
    end

endmodule

// File: rtl/rv_pipe_decode.sv
/*
 * Decode stage
 * Turns the subset into micro-ops, forwards operands and bubbles on hazards
 */
`timescale 1ns/100ps

module rv_pipe_decode import rv_pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  addr_t     instr_pc,
    input  word_t     instr_word,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    fwd_if.dst        fwd_ex,
    fwd_if.dst        fwd_wb,
    stage_if.src      out
);

    uop_t      uop;
    reg_addr_t dst;                                 // Zero for NOP and STORE
    word_t     imm;
    word_t     imm_i;
    word_t     imm_s;
    logic      use_imm;
    logic      use_rs1;
    logic      use_rs2;
    reg_addr_t rs  [2];
    word_t     rf  [2];
    word_t     opr [2];                             // Forwarded operands
    logic      stall;                               // Producer data not ready
    logic      out_free;

    assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
    assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};

    // ------------------------------------------------------------
    // Instruction decode
    // ------------------------------------------------------------
    always_comb begin
        uop     = NOP;
        imm     = '0;
        use_imm = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        dst     = '0;
        case (instr_word[6:0])
            OPC_LUI: begin
                uop     = PASS_B;
                imm     = {instr_word[31:12], 12'b0};
                use_imm = 1'b1;
            end
            OPC_OP_IMM: if (instr_word[14:12] == 3'b000) begin
                uop     = ADD;                      // ADDI
                imm     = imm_i;
                use_imm = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({instr_word[31:25], instr_word[14:12]})
                    10'b0000000_000: uop = ADD;
                    10'b0100000_000: uop = SUB;
                    10'b0000000_111: uop = AND;
                    10'b0000000_110: uop = OR;
                    10'b0000000_100: uop = XOR;
                    default:         uop = NOP;
                endcase
            end
            OPC_LOAD: if (instr_word[14:12] == 3'b010) begin
                uop     = LOAD;                     // LW only
                imm     = imm_i;
                use_imm = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_STORE: if (instr_word[14:12] == 3'b010) begin
                uop     = STORE;                    // SW only
                imm     = imm_s;
                use_imm = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: uop = NOP;
        endcase
        if (uop == NOP) begin
            use_rs1 = 1'b0;                         // Unknown encodings read nothing
            use_rs2 = 1'b0;
        end
        if (uop != NOP && uop != STORE) begin
            dst = instr_word[11:7];
        end
    end

    // Unused sources read as x0 and so never match a producer
    assign rs1_addr = use_rs1 ? instr_word[19:15] : '0;
    assign rs2_addr = use_rs2 ? instr_word[24:20] : '0;
    assign rs[0]    = rs1_addr;
    assign rs[1]    = rs2_addr;
    assign rf[0]    = rs1_data;
    assign rf[1]    = rs2_data;

    // ------------------------------------------------------------
    // Hazards and forwarding
    // ------------------------------------------------------------
    always_comb begin : hazard
        logic hit_de;
        logic hit_ex;
        logic hit_wb;
        stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            hit_de = out.valid && rs[i] != '0 && rs[i] == out.rd;      // Not computed yet
            hit_ex = fwd_ex.valid && rs[i] != '0 && rs[i] == fwd_ex.rd;
            hit_wb = fwd_wb.valid && rs[i] != '0 && rs[i] == fwd_wb.rd;
            opr[i] = hit_ex ? fwd_ex.data : hit_wb ? fwd_wb.data : rf[i];
            if (hit_de || (hit_ex && fwd_ex.is_load) || (!hit_ex && hit_wb && fwd_wb.is_load))
                stall = 1'b1;
        end
    end

    assign out_free    = !out.valid || out.ready;
    assign instr_ready = out_free && !stall;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (out_free) begin
            out.valid <= instr_valid && !stall;     // Bubble while stalled
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid && instr_ready) begin
            out.pc         <= instr_pc;
            out.instr      <= instr_word;
            out.rd         <= dst;
            out.uop        <= uop;
            out.opr_a      <= opr[0];
            out.opr_b      <= use_imm ? imm : opr[1];
            out.store_data <= opr[1];
        end
    end

endmodule

// File: rtl/rv_pipe_execute.sv
/*
 * Execute stage
 * ALU result or load/store effective address into the stage register
 */
`timescale 1ns/100ps

module rv_pipe_execute import rv_pipe_pkg::*; (
    input  logic g_clk,
    input  logic rst,
    stage_if.dst in,
    stage_if.src out,
    fwd_if.src   fwd
);

    word_t result;

    always_comb begin
        case (in.uop)
            ADD, LOAD, STORE: result = in.opr_a + in.opr_b;     // Shared adder
            SUB:              result = in.opr_a - in.opr_b;
            AND:              result = in.opr_a & in.opr_b;
            OR:               result = in.opr_a | in.opr_b;
            XOR:              result = in.opr_a ^ in.opr_b;
            PASS_B:           result = in.opr_b;
            default:          result = '0;
        endcase
    end

    assign in.ready = !out.valid || out.ready;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (in.ready) begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (in.valid && in.ready) begin
            out.pc         <= in.pc;
            out.instr      <= in.instr;
            out.rd         <= in.rd;
            out.uop        <= in.uop;
            out.opr_a      <= result;               // Result or address
            out.opr_b      <= in.opr_b;             // Immediate or rs2 value
            out.store_data <= in.store_data;
        end
    end

    // Report the held instruction
    assign fwd.valid   = out.valid;
    assign fwd.rd      = out.rd;
    assign fwd.data    = out.opr_a;
    assign fwd.is_load = out.uop == LOAD;

endmodule

// File: rtl/rv_pipe_memwb.sv
/*
 * Memory and writeback stage
 * Issues loads and stores, writes results back and drives the trace port
 */
`timescale 1ns/100ps

module rv_pipe_memwb import rv_pipe_pkg::*; (
    input  logic          g_clk,
    input  logic          rst,
    stage_if.dst          in,
    mem_port_if.requester mem,
    fwd_if.src            fwd,
    output logic          rd_wen,
    output reg_addr_t     rd_addr,
    output word_t         rd_data,
    output logic          trs_valid,
    output addr_t         trs_pc,
    output word_t         trs_instr
);

    logic      valid;
    logic      granted;                             // Access waiting for recv
    logic      is_mem;
    logic      done;                                // Retires this cycle
    uop_t      uop;
    reg_addr_t rd;
    word_t     result;                              // ALU result or address
    word_t     wdata;
    addr_t     pc;
    word_t     instr;

    assign is_mem   = uop == LOAD || uop == STORE;
    assign done     = valid && (!is_mem || mem.recv);
    assign in.ready = !valid || done;

    assign mem.req   = valid && is_mem && !granted;
    assign mem.wen   = uop == STORE;
    assign mem.addr  = result;
    assign mem.wdata = wdata;

    assign rd_data   = uop == LOAD ? mem.rdata : result;
    assign rd_addr   = rd;
    assign rd_wen    = done && rd != '0;            // x0 never written
    assign trs_valid = done;
    assign trs_pc    = pc;
    assign trs_instr = instr;

    assign fwd.valid   = valid;
    assign fwd.rd      = rd;
    assign fwd.data    = rd_data;
    assign fwd.is_load = uop == LOAD && !mem.recv;  // Data only in recv cycle

    always_ff @(posedge g_clk) begin
        if (rst) begin
            valid   <= 1'b0;
            granted <= 1'b0;
        end else begin
            if (in.valid && in.ready) begin
                valid <= 1'b1;
            end else if (done) begin
                valid <= 1'b0;
            end
            if (mem.req && mem.gnt) begin
                granted <= 1'b1;
            end else if (mem.recv) begin
                granted <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (in.valid && in.ready) begin
            uop    <= in.uop;
            rd     <= in.rd;
            result <= in.opr_a;
            wdata  <= in.store_data;
            pc     <= in.pc;
            instr  <= in.instr;
        end
    end

endmodule

// File: rtl/rv_pipe_regfile.sv
/*
 * General purpose registers
 * x1 to x31, two combinational read ports with write bypass, x0 reads zero
 */
`timescale 1ns/100ps

module rv_pipe_regfile import rv_pipe_pkg::*; (
    input  logic      g_clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      rd_wen,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);

    word_t regs [1:31];

    // Same-cycle write is visible on the read ports
    assign rs1_data = rs1_addr == '0 ? '0 :
                      (rd_wen && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
    assign rs2_data = rs2_addr == '0 ? '0 :
                      (rd_wen && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!rst && rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;               // No writes held in reset
        end
    end

endmodule

// File: rtl/rv_mem_arbiter.sv
/*
 * Memory bus arbiter
 * Memory stage wins over fetch, one transaction at a time, recv steered back
 */
`timescale 1ns/100ps

module rv_mem_arbiter import rv_pipe_pkg::*; (
    input  logic        g_clk,
    input  logic        rst,
    mem_port_if.arbiter fetch,
    mem_port_if.arbiter memory,
    output logic        mem_req,
    output logic        mem_wen,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    input  logic        mem_gnt,
    input  logic        mem_recv,
    input  word_t       mem_rdata
);

    arb_owner_t owner;                              // Locked or outstanding owner
    arb_owner_t sel;                                // Requester shown on the bus
    logic       busy;                               // Granted, awaiting recv
    logic       locked;                             // Shown without grant

    // A request on the bus stays selected until granted
    always_comb begin
        if (locked)          sel = owner;
        else if (memory.req) sel = MEMORY;
        else                 sel = FETCH;
    end

    assign mem_req   = !busy && (sel == MEMORY ? memory.req : fetch.req);
    assign mem_wen   = sel == MEMORY ? memory.wen   : fetch.wen;
    assign mem_addr  = sel == MEMORY ? memory.addr  : fetch.addr;
    assign mem_wdata = sel == MEMORY ? memory.wdata : fetch.wdata;

    assign memory.gnt   = mem_req && mem_gnt && sel == MEMORY;
    assign fetch.gnt    = mem_req && mem_gnt && sel == FETCH;
    assign memory.recv  = mem_recv && busy && owner == MEMORY;
    assign fetch.recv   = mem_recv && busy && owner == FETCH;
    assign memory.rdata = mem_rdata;
    assign fetch.rdata  = mem_rdata;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            owner  <= FETCH;
            busy   <= 1'b0;
            locked <= 1'b0;
        end else begin
            if (mem_req) begin
                owner  <= sel;
                locked <= !mem_gnt;
            end
            if (mem_req && mem_gnt) begin
                busy <= 1'b1;
            end else if (mem_recv) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/rv_pipeline.sv
/*
 * RV32 pipeline top level
 * Fetch, decode, execute and memwb stages sharing one memory bus
 */
`timescale 1ns/100ps

module rv_pipeline import rv_pipe_pkg::*; (
    input  logic  g_clk,
    input  logic  rst,
    output logic  mem_req,
    output logic  mem_wen,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_gnt,
    input  logic  mem_recv,
    input  word_t mem_rdata,
    output logic  trs_valid,
    output addr_t trs_pc,
    output word_t trs_instr
);

    logic      instr_valid;                         // Fetch to decode
    logic      instr_ready;
    addr_t     instr_pc;
    word_t     instr_word;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rd_wen;                              // Writeback port
    reg_addr_t rd_addr;
    word_t     rd_data;

    stage_if    de_bus ();
    stage_if    em_bus ();
    mem_port_if fetch_port ();
    mem_port_if data_port ();
    fwd_if      fwd_ex ();
    fwd_if      fwd_wb ();

    rv_pipe_fetch u_fetch (
        .g_clk(g_clk), .rst(rst), .mem(fetch_port),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_pc(instr_pc), .instr_word(instr_word)
    );

    rv_pipe_decode u_decode (
        .g_clk(g_clk), .rst(rst),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .instr_pc(instr_pc), .instr_word(instr_word),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .fwd_ex(fwd_ex), .fwd_wb(fwd_wb), .out(de_bus)
    );

    rv_pipe_execute u_execute (
        .g_clk(g_clk), .rst(rst), .in(de_bus), .out(em_bus), .fwd(fwd_ex)
    );

    rv_pipe_memwb u_memwb (
        .g_clk(g_clk), .rst(rst), .in(em_bus), .mem(data_port), .fwd(fwd_wb),
        .rd_wen(rd_wen), .rd_addr(rd_addr), .rd_data(rd_data),
        .trs_valid(trs_valid), .trs_pc(trs_pc), .trs_instr(trs_instr)
    );

    rv_pipe_regfile u_regfile (
        .g_clk(g_clk), .rst(rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_wen(rd_wen), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    rv_mem_arbiter u_arbiter (
        .g_clk(g_clk), .rst(rst), .fetch(fetch_port), .memory(data_port),
        .mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_gnt(mem_gnt), .mem_recv(mem_recv),
        .mem_rdata(mem_rdata)
    );

endmodule

// File: verif/rv_pipeline_assert.sv
/*
 * Memory bus checks bound to the pipeline top level
 * Request held until grant and recv only when a grant is owed
 */
`timescale 1ns/100ps

module rv_pipeline_assert import rv_pipe_pkg::*; (
    input logic  g_clk,
    input logic  rst,
    input logic  mem_req,
    input logic  mem_wen,
    input addr_t mem_addr,
    input word_t mem_wdata,
    input logic  mem_gnt,
    input logic  mem_recv
);

    logic outstanding;                              // Granted, recv not seen yet

    always_ff @(posedge g_clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (mem_req && mem_gnt) begin
            outstanding <= 1'b1;
        end else if (mem_recv) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge g_clk) disable iff (rst)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_wen) && $stable(mem_addr)
                                && $stable(mem_wdata))
        else $error("memory request dropped or changed before its grant");

    recv_owed: assert property (@(posedge g_clk) disable iff (rst)
        mem_recv |-> outstanding)
        else $error("mem_recv without an outstanding grant");

endmodule

bind rv_pipeline rv_pipeline_assert u_bus_assert (
    .g_clk(g_clk), .rst(rst), .mem_req(mem_req), .mem_wen(mem_wen),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_gnt(mem_gnt), .mem_recv(mem_recv)
);

// File: verif/rv_pipeline_tb.sv
/*
 * RV pipeline testbench
 * Runs the pattern file program on a memory model with random grant and
 * response delays, checks reset state, trace order and the store sequence
 */
`timescale 1ns/100ps

module rv_pipeline_tb import rv_pipe_pkg::*; ();

    logic  g_clk;
    logic  rst;
    logic  mem_req;
    logic  mem_wen;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_gnt;
    logic  mem_recv;
    word_t mem_rdata;
    logic  trs_valid;
    addr_t trs_pc;
    word_t trs_instr;

    word_t  pat [0:255];                            // Pattern file image
    word_t  mem [0:255];                            // 1 KB memory model
    integer seed;
    string  test_name [8];
    int     errs [8];                               // Failed checks per test
    int     n_retire;                               // Program length in words
    int     n_stores;
    int     store_idx;                              // Stores seen so far
    int     retired;
    int     prog_retired;                           // Retires inside the program
    addr_t  exp_pc;
    int     gnt_wait;                               // -1 when not counting
    int     rsp_wait;
    logic   rsp_pending;
    word_t  rsp_data;

    rv_pipeline dut (
        .g_clk(g_clk), .rst(rst),
        .mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_gnt(mem_gnt), .mem_recv(mem_recv),
        .mem_rdata(mem_rdata),
        .trs_valid(trs_valid), .trs_pc(trs_pc), .trs_instr(trs_instr)
    );

    initial g_clk = 1'b0;
    always #2 g_clk = ~g_clk;                       // 4 ns period

    task automatic report_mismatch(int test, string sig, word_t got, word_t exp);
        errs[test]++;
        $display("FAILED %0t %s got %h expected %h", $time, sig, got, exp);
    endtask

    task automatic report_problem(int test, string what);
        errs[test]++;
        $display("At %0t: %s", $time, what);
    endtask

    task automatic finish_test(int test);
        $display("Test %s %s", test_name[test], errs[test] == 0 ? "passed" : "failed");
    endtask

    // Expected stores sit at 0xC2 as group, address, data triples
    task automatic check_store(addr_t addr, word_t data);
        int base;
        int test;
        if (store_idx >= n_stores) begin
            report_problem(6, $sformatf("store of %h to %h beyond the expected list",
                                        data, addr));
        end else begin
            base = 'hC2 + 3 * store_idx;
            test = 2 + int'(pat[base]);             // Group 1..3 to test 3..5
            assert (addr == pat[base+1])
                else report_mismatch(test, "mem_addr", addr, pat[base+1]);
            assert (data == pat[base+2])
                else report_mismatch(test, "mem_wdata", data, pat[base+2]);
        end
        store_idx++;
    endtask

    // ------------------------------------------------------------
    // Memory model with grant after 0..3 cycles and recv 1..3 after grant
    // ------------------------------------------------------------
    always @(posedge g_clk) begin : mem_model
        logic  gnt_n;
        logic  recv_n;
        word_t rdata_n;
        gnt_n   = mem_gnt;
        recv_n  = 1'b0;                             // Single cycle pulse
        rdata_n = mem_rdata;
        if (rst) begin
            gnt_n       = 1'b0;
            rsp_pending = 1'b0;
            gnt_wait    = -1;
        end else begin
            if (mem_req && mem_gnt) begin           // Accepted on this edge
                if (mem_wen) begin
                    check_store(mem_addr, mem_wdata);
                    mem[mem_addr[9:2]] = mem_wdata;
                end
                rsp_data    = mem[mem_addr[9:2]];
                rsp_pending = 1'b1;
                rsp_wait    = $unsigned($random(seed)) % 3;
                gnt_n       = 1'b0;
                gnt_wait    = -1;
            end else if (mem_req) begin
                if (gnt_wait < 0)
                    gnt_wait = $unsigned($random(seed)) % 4;
                if (gnt_wait == 0)
                    gnt_n = 1'b1;
                else
                    gnt_wait--;
            end else begin
                gnt_n = 1'b0;
            end
            if (rsp_pending) begin
                if (rsp_wait == 0) begin
                    recv_n      = 1'b1;
                    rdata_n     = rsp_data;
                    rsp_pending = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
        end
        #1;
        mem_gnt   <= gnt_n;
        mem_recv  <= recv_n;
        mem_rdata <= rdata_n;
    end

    // Trace monitor checking program order from PC_RESET
    always @(posedge g_clk) begin
        if (!rst && trs_valid) begin
            assert (trs_pc == exp_pc) else report_mismatch(2, "trs_pc", trs_pc, exp_pc);
            assert (trs_instr == pat[exp_pc[9:2]])
                else report_mismatch(2, "trs_instr", trs_instr, pat[exp_pc[9:2]]);
            if (trs_pc < addr_t'(n_retire * 4))
                prog_retired++;
            exp_pc = exp_pc + 32'd4;
            retired++;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : main
        int waited;
        int failed;
        int checks;
        seed      = 32'h7bb517a7;
        test_name = '{"reset_state", "first_fetch", "trace_order", "alu_chain",
                      "load_use", "zero_reg", "store_count", "retire_count"};
        rst       = 1'b1;
        mem_gnt   = 1'b0;
        mem_recv  = 1'b0;
        mem_rdata = '0;
        for (int t = 0; t < 8; t++)
            errs[t] = 0;
        retired      = 0;
        prog_retired = 0;
        store_idx    = 0;
        exp_pc       = PC_RESET;
        gnt_wait     = -1;
        rsp_wait     = 0;
        rsp_pending  = 1'b0;
        rsp_data     = '0;
        for (int i = 0; i < 256; i++)
            pat[i] = {i[23:0], 8'h7F};              // Opcode 0x7F decodes as NOP
        $readmemh("verif/program_patterns.txt", pat);
        for (int i = 0; i < 256; i++)
            mem[i] = i < 'hC0 ? pat[i] : {i[23:0], 8'h7F};
        n_retire = int'(pat['hC0]);
        n_stores = int'(pat['hC1]);

        // Bus and trace quiet through reset and one cycle after
        for (int c = 1; c <= 16; c++) begin
            @(posedge g_clk);
            if (c > 1) begin
                assert (mem_req == 1'b0) else report_mismatch(0, "mem_req", 32'(mem_req), 0);
                assert (trs_valid == 1'b0)
                    else report_mismatch(0, "trs_valid", 32'(trs_valid), 0);
            end
        end
        #1 rst = 1'b0;
        @(posedge g_clk);
        assert (mem_req == 1'b0) else report_mismatch(0, "mem_req", 32'(mem_req), 0);
        assert (trs_valid == 1'b0) else report_mismatch(0, "trs_valid", 32'(trs_valid), 0);
        finish_test(0);

        waited = 0;
        while (!mem_req && waited < 50) begin
            @(posedge g_clk);
            waited++;
        end
        if (!mem_req) begin
            report_problem(1, "no memory request within 50 cycles after reset");
        end else begin
            assert (mem_addr == PC_RESET) else report_mismatch(1, "mem_addr", mem_addr, PC_RESET);
            assert (mem_wen == 1'b0) else report_mismatch(1, "mem_wen", 32'(mem_wen), 0);
        end
        finish_test(1);

        waited = 0;
        while (retired < n_retire && waited < 4000) begin
            @(negedge g_clk);
            waited++;
        end
        if (retired < n_retire)
            report_problem(7, $sformatf("only %0d of %0d instructions retired in time",
                                        retired, n_retire));
        repeat (20) @(negedge g_clk);               // Catch late or repeated stores
        finish_test(2);
        finish_test(3);
        finish_test(4);
        finish_test(5);
        assert (store_idx == n_stores) else report_mismatch(6, "store_count", store_idx, n_stores);
        finish_test(6);
        assert (prog_retired == n_retire)
            else report_mismatch(7, "retire_count", prog_retired, n_retire);
        finish_test(7);

        failed = 0;
        checks = 0;
        for (int t = 0; t < 8; t++) begin
            if (errs[t] != 0)
                failed++;
            checks += errs[t];
        end
        $display("Tests run 8, passed %0d, failed %0d, failed checks %0d",
                 8 - failed, failed, checks);
        if (checks == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verif/program_patterns.txt
// Program words from @000, data words from @040 (byte 0x100), results from @0C0
// @0C0 retire count and store count, then per store: group (1 alu, 2 load, 3 x0), address, data
@000
20000093 00500113 00710193 00218233
403202B3 0042C333 0060A023 123453B7
0063E433 004474B3 0080A223 0090A423
10000513 00052583 01158613 00C0A623
00452683 00B6C733 00E0A823 05500013
0000AA23 FE060793 00F0AC23 00000000
00000000 00000000 00000000 00000000
00000000
@040
13579BDF 0F0F00FF
@0C0
00000017 00000007
00000001 00000200 00000014
00000001 00000204 12345014
00000001 00000208 00000010
00000002 0000020C 13579BF0
00000002 00000210 1C589B20
00000003 00000214 00000000
00000001 00000218 13579BD0

// File: rv_pipeline.f
rtl/rv_pipe_pkg.sv
rtl/rv_pipe_if.sv
rtl/rv_pipe_fetch.sv
rtl/rv_pipe_decode.sv
rtl/rv_pipe_execute.sv
rtl/rv_pipe_memwb.sv
rtl/rv_pipe_regfile.sv
rtl/rv_mem_arbiter.sv
rtl/rv_pipeline.sv
verif/rv_pipeline_assert.sv
verif/rv_pipeline_tb.sv

// File: Makefile
TOOL     = verilator
TOP      = rv_pipeline_tb
FILELIST = rv_pipeline.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
